//--- bench/lzss_checker.sv
`timescale 1ns/1ps

module lzss_checker (
    input logic                             clk,
    input logic                             reset,
    input logic                             out_valid,
    input logic                             out_ready,
    input lzss_pkg::codeword_t              out_codeword,
    input logic [lzss_pkg::COUNT_WIDTH-1:0] enc_num,
    input logic                             finish
);

    lzss_pkg::codeword_t expected [$];
    lzss_pkg::codeword_t held;
    int transfers      = 0;
    int value_errors   = 0;
    int other_failures = 0;
    bit stalled        = 1'b0;
    bit finished       = 1'b0;

    task automatic clear_expected();
        expected.delete();
        transfers = 0;
    endtask

    task automatic push_expected(input lzss_pkg::codeword_t cw);
        expected.push_back(cw);
    endtask

    // Sampled mid-cycle when all DUT outputs have settled
    always @(negedge clk) begin
        if (reset) begin
            stalled  = 1'b0;
            finished = 1'b0;
        end else begin
            // A stalled codeword must survive unchanged into this cycle
            if (stalled && (!out_valid || out_codeword !== held)) begin
                $display("Error at time %0t: out_codeword held %03h, actual %03h, out_valid %b",
                         $time, held, out_codeword, out_valid);
                value_errors++;
            end
            if (int'(enc_num) != transfers) begin
                $display("Error at time %0t: enc_num expected %0d, actual %0d",
                         $time, transfers, enc_num);
                value_errors++;
            end
            // finish waits for the whole sequence and then holds until reset
            if (finish && !finished) begin
                if (transfers != expected.size()) begin
                    $display("finish rose after %0d of %0d codewords",
                             transfers, expected.size());
                    other_failures++;
                end
                if (int'(enc_num) != expected.size()) begin
                    $display("Error at time %0t: enc_num expected %0d, actual %0d",
                             $time, expected.size(), enc_num);
                    value_errors++;
                end
            end
            if (finished && !finish) begin
                $display("finish dropped at time %0t before reset", $time);
                other_failures++;
            end
            finished = finish;
            // Handshake seen now completes on the next rising edge
            if (out_valid && out_ready) begin
                if (transfers >= expected.size()) begin
                    $display("Codeword %03h arrived after the expected sequence ended",
                             out_codeword);
                    other_failures++;
                end else if (out_codeword !== expected[transfers]) begin
                    $display("Error at time %0t: out_codeword expected %03h, actual %03h",
                             $time, expected[transfers], out_codeword);
                    value_errors++;
                end
                transfers++;
            end
            stalled = out_valid && !out_ready;
            held    = out_codeword;
        end
    end

endmodule

//--- bench/tb_lzss.sv
`timescale 1ns/1ps

module tb_lzss;

    localparam int CLK_PERIOD  = 4;
    localparam int RAND_SHORT  = 60;
    localparam int RAND_MID    = 120;
    localparam int RAND_LONG   = 300;
    localparam int TOTAL_BYTES = 40 + 15 + RAND_SHORT + RAND_MID + RAND_LONG;
    // 12 cycles per byte, stretched by the 1-in-4 stall rate, plus resets
    localparam int TIMEOUT_CYCLES = TOTAL_BYTES * 12 * 4 / 3 + 5 * 20;

    logic                             clk;
    logic                             reset;
    logic                             in_valid;
    lzss_pkg::byte_beat_t             in_beat;
    logic                             in_ready;
    logic                             out_valid;
    logic                             out_ready = 1'b0;
    lzss_pkg::codeword_t              out_codeword;
    logic [lzss_pkg::COUNT_WIDTH-1:0] enc_num;
    logic                             finish;

    logic [31:0] lfsr_state = 32'h3ce3;
    logic [7:0]  stream [$];
    logic        stall_enable;
    logic        stall_next;
    int          other_failures = 0;

    lzss_encoder uut (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_beat      (in_beat),
        .in_ready     (in_ready),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_codeword (out_codeword),
        .enc_num      (enc_num),
        .finish       (finish)
    );

    lzss_checker chk (
        .clk          (clk),
        .reset        (reset),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_codeword (out_codeword),
        .enc_num      (enc_num),
        .finish       (finish)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Galois LFSR over x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] lfsr_take(input int nbits);
        logic [31:0] bits;
        bits = '0;
        for (int b = 0; b < nbits; b++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
        end
        return bits;
    endfunction

    // Longest run first, then the most recent; offset i ends the run i+1 bytes back
    function automatic lzss_pkg::codeword_t reference_codeword(input int pos, output int used);
        lzss_pkg::codeword_t cw;
        int avail;
        int span;
        bit same;
        avail = stream.size() - pos;
        span  = (pos < lzss_pkg::WINDOW_SIZE) ? pos : lzss_pkg::WINDOW_SIZE;
        cw.is_match = 1'b0;
        cw.field    = stream[pos];
        cw.len_code = lzss_pkg::LEN2;
        used        = 1;
        for (int len = lzss_pkg::MAX_MATCH; len >= lzss_pkg::MIN_MATCH; len--) begin
            for (int off = 0; off + len <= span && used == 1 && len <= avail; off++) begin
                same = 1'b1;
                for (int k = 0; k < len; k++) begin
                    if (stream[pos - off - len + k] != stream[pos + k]) begin
                        same = 1'b0;
                    end
                end
                if (same) begin
                    cw.is_match = 1'b1;
                    cw.field    = 8'(off);
                    cw.len_code = lzss_pkg::len_code_e'(len - lzss_pkg::MIN_MATCH);
                    used        = len;
                end
            end
        end
        return cw;
    endfunction

    // Stall drawn mid-cycle and applied on the next rising edge
    always @(negedge clk) begin
        stall_next = (lfsr_take(2) == 32'd0);
    end

    always @(posedge clk) begin
        out_ready <= !reset && !(stall_enable && stall_next);
    end

    task automatic apply_reset(input logic stalls);
        @(posedge clk);
        reset        <= 1'b1;
        in_valid     <= 1'b0;
        stall_enable <= stalls;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    endtask

    // Four-letter alphabet so that repeats are frequent
    task automatic make_random_stream(input int n);
        @(posedge clk);
        stream.delete();
        for (int i = 0; i < n; i++) begin
            stream.push_back(8'h61 + 8'(lfsr_take(2)));
        end
    endtask

    task automatic drive_stream(input logic gaps);
        int idx;
        idx = 0;
        while (idx < stream.size()) begin
            @(posedge clk);
            if (gaps && lfsr_take(2) == 32'd0) begin
                in_valid <= 1'b0;
                @(posedge clk);
            end
            in_valid     <= 1'b1;
            in_beat.data <= stream[idx];
            in_beat.last <= (idx == stream.size() - 1);
            @(negedge clk);
            while (!in_ready) @(negedge clk);
            idx++;
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic run_stream(input logic random_timing);
        lzss_pkg::codeword_t cw;
        int pos;
        int used;
        apply_reset(random_timing);
        chk.clear_expected();
        pos = 0;
        while (pos < stream.size()) begin
            cw = reference_codeword(pos, used);
            chk.push_expected(cw);
            pos += used;
        end
        drive_stream(random_timing);
        @(negedge clk);
        while (!finish) @(negedge clk);
        // A few cycles with finish held before the next reset
        repeat (4) @(negedge clk);
    endtask

    task automatic finish_run();
        int total_values;
        int total_other;
        total_values = chk.value_errors;
        total_other  = other_failures + chk.other_failures;
        $display("Summary: %0d wrong values, %0d other failures", total_values, total_other);
        if (total_values == 0 && total_other == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    initial begin
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_beat      = '0;
        stall_enable = 1'b0;

        // No byte pair repeats, so only literals
        stream.delete();
        for (int i = 0; i < 40; i++) begin
            stream.push_back(8'(i * 37 + 5));
        end
        run_stream(1'b0);

        // Three copies of a five-byte pattern
        stream.delete();
        for (int i = 0; i < 15; i++) begin
            stream.push_back(8'h10 * 8'(i % 5 + 1));
        end
        run_stream(1'b0);

        make_random_stream(RAND_SHORT);
        run_stream(1'b0);
        make_random_stream(RAND_MID);
        run_stream(1'b1);
        // Longer than the window with gaps and stalls
        make_random_stream(RAND_LONG);
        run_stream(1'b1);
        finish_run();
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the encoder did not finish all streams within %0d cycles",
                 TIMEOUT_CYCLES);
        other_failures++;
        finish_run();
    end

endmodule

//--- hdl/encode_control.sv
`timescale 1ns/1ps

module encode_control (
    input  logic                                clk,
    input  logic                                reset,
    input  lzss_pkg::lookahead_t                look,
    input  logic                                stream_done,
    input  lzss_pkg::codeword_t                 cand,
    input  logic [2:0]                          cand_len,
    output logic                                shift,
    output logic                                out_valid,
    input  logic                                out_ready,
    output lzss_pkg::codeword_t                 out_codeword,
    output logic [lzss_pkg::COUNT_WIDTH-1:0]    enc_num,
    output logic                                finish
);

    typedef enum logic [2:0] {
        WAIT_FILL,
        SETTLE,
        EMIT,
        SHIFTING,
        DONE
    } state_e;

    state_e     state;
    logic [2:0] remaining;
    logic       can_decide;
    logic       transfer;

    assign transfer = out_valid && out_ready;

    // Full window, or the tail of the stream once the last beat is in
    assign can_decide = (look.count == 3'(lzss_pkg::MAX_MATCH)) ||
                        (stream_done && look.count != '0);

    assign shift  = (state == SHIFTING);
    assign finish = (state == DONE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= WAIT_FILL;
            remaining <= '0;
        end else begin
            case (state)
                WAIT_FILL: begin
                    // Lookahead is frozen here, so the compare table settles
                    if (can_decide) begin
                        state <= SETTLE;
                    end
                end
                SETTLE: begin
                    remaining <= cand_len;
                    state     <= SHIFTING;
                end
                SHIFTING: begin
                    remaining <= remaining - 1'b1;
                    if (remaining == 3'd1) begin
                        state <= EMIT;
                    end
                end
                EMIT: begin
                    // Hold until the codeword has gone out
                    if (!out_valid || out_ready) begin
                        if (stream_done && look.count == '0) begin
                            state <= DONE;
                        end else begin
                            state <= WAIT_FILL;
                        end
                    end
                end
                DONE: begin
                    state <= DONE;
                end
                default: begin
                    state <= WAIT_FILL;
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
            enc_num   <= '0;
        end else begin
            if (state == SETTLE) begin
                out_valid <= 1'b1;
            end else if (transfer) begin
                out_valid <= 1'b0;
            end
            if (transfer) begin
                enc_num <= enc_num + 1'b1;
            end
        end
    end

    // Captured once per decision, held through back-pressure
    always_ff @(posedge clk) begin
        if (state == SETTLE) begin
            out_codeword <= cand;
        end
    end

    stall_holds_codeword: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_codeword)
    );

endmodule

//--- hdl/history_window.sv
`timescale 1ns/1ps

module history_window (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    shift,
    input  lzss_pkg::lookahead_t    look,
    output lzss_pkg::match_flags_t  flags
);

    logic [7:0] hist [lzss_pkg::WINDOW_SIZE];
    logic [$clog2(lzss_pkg::WINDOW_SIZE + 1) - 1:0] fill;

    // Compare table, row k is lookahead byte k, column i is history byte i
    logic [lzss_pkg::MAX_MATCH-1:0][lzss_pkg::WINDOW_SIZE-1:0] eq_q;
    logic [lzss_pkg::NUM_LENGTHS-1:0][lzss_pkg::WINDOW_SIZE-1:0] diag;

    // hist[0] is the newest byte
    always_ff @(posedge clk) begin
        if (shift) begin
            hist[0] <= look.bytes[0];
            for (int i = 1; i < lzss_pkg::WINDOW_SIZE; i++) begin
                hist[i] <= hist[i-1];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fill <= '0;
        end else if (shift && fill != lzss_pkg::WINDOW_SIZE) begin
            fill <= fill + 1'b1;
        end
    end

    // Entries outside the filled history or the valid lookahead never match
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            eq_q <= '0;
        end else begin
            for (int k = 0; k < lzss_pkg::MAX_MATCH; k++) begin
                for (int i = 0; i < lzss_pkg::WINDOW_SIZE; i++) begin
                    eq_q[k][i] <= (look.bytes[k] == hist[i]) && (i < fill) &&
                                  (k < look.count);
                end
            end
        end
    end

    // Length L at offset i needs byte k against history i + L - 1 - k
    always_comb begin
        int pos;
        pos = 0;
        for (int l = 0; l < lzss_pkg::NUM_LENGTHS; l++) begin
            for (int i = 0; i < lzss_pkg::WINDOW_SIZE; i++) begin
                diag[l][i] = 1'b1;
                for (int k = 0; k < l + lzss_pkg::MIN_MATCH; k++) begin
                    pos = i + l + lzss_pkg::MIN_MATCH - 1 - k;
                    if (pos < lzss_pkg::WINDOW_SIZE) begin
                        diag[l][i] = diag[l][i] & eq_q[k][pos];
                    end else begin
                        diag[l][i] = 1'b0;
                    end
                end
            end
        end
    end

    assign flags = '{len5: diag[3], len4: diag[2], len3: diag[1], len2: diag[0]};

endmodule

//--- hdl/lookahead_buffer.sv
`timescale 1ns/1ps

module lookahead_buffer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  lzss_pkg::byte_beat_t   in_beat,
    output logic                   in_ready,
    input  logic                   shift,
    output lzss_pkg::lookahead_t   look,
    output logic                   stream_done
);

    logic [lzss_pkg::MAX_MATCH-1:0][7:0] slot;
    logic [2:0] count;
    logic [2:0] count_next;
    logic [2:0] wr_pos;
    logic       seen_last;
    logic       accept;

    assign accept     = in_valid && in_ready;
    assign count_next = count + 3'(accept) - 3'(shift);

    // A shift in the same cycle moves the free slot down by one
    assign wr_pos = count - 3'(shift);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count     <= '0;
            seen_last <= 1'b0;
            in_ready  <= 1'b0;
        end else begin
            count <= count_next;
            if (accept && in_beat.last) begin
                seen_last <= 1'b1;
            end
            // Ready for the following cycle, from the updated fill state
            in_ready <= (count_next < lzss_pkg::MAX_MATCH) &&
                        !(seen_last || (accept && in_beat.last));
        end
    end

    // Byte queue, slot 0 leaves first
    always_ff @(posedge clk) begin
        if (shift) begin
            for (int i = 0; i < lzss_pkg::MAX_MATCH - 1; i++) begin
                slot[i] <= slot[i+1];
            end
        end
        if (accept) begin
            slot[wr_pos] <= in_beat.data;
        end
    end

    assign look        = '{bytes: slot, count: count};
    assign stream_done = seen_last;

    // The control must never consume a byte that is not there
    shift_needs_data: assert property (
        @(posedge clk) disable iff (reset) shift |-> count != '0
    );

endmodule

//--- hdl/lzss_encoder.sv
`timescale 1ns/1ps

module lzss_encoder (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                in_valid,
    input  lzss_pkg::byte_beat_t                in_beat,
    output logic                                in_ready,
    output logic                                out_valid,
    input  logic                                out_ready,
    output lzss_pkg::codeword_t                 out_codeword,
    output logic [lzss_pkg::COUNT_WIDTH-1:0]    enc_num,
    output logic                                finish
);

    lzss_pkg::lookahead_t    look;
    lzss_pkg::match_flags_t  flags;
    lzss_pkg::codeword_t     cand;
    logic [2:0]              cand_len;
    logic                    stream_done;
    logic                    shift;

    lookahead_buffer u_lookahead (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_beat     (in_beat),
        .in_ready    (in_ready),
        .shift       (shift),
        .look        (look),
        .stream_done (stream_done)
    );

    // Shares the shift pulse so the consumed byte enters the history
    history_window u_history (
        .clk   (clk),
        .reset (reset),
        .shift (shift),
        .look  (look),
        .flags (flags)
    );

    match_select u_select (
        .flags    (flags),
        .look     (look),
        .cand     (cand),
        .cand_len (cand_len)
    );

    encode_control u_control (
        .clk          (clk),
        .reset        (reset),
        .look         (look),
        .stream_done  (stream_done),
        .cand         (cand),
        .cand_len     (cand_len),
        .shift        (shift),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_codeword (out_codeword),
        .enc_num      (enc_num),
        .finish       (finish)
    );

endmodule

//--- hdl/lzss_pkg.sv
package lzss_pkg;

    // Window and match geometry
    localparam int WINDOW_SIZE = 256;
    localparam int MAX_MATCH   = 5;
    localparam int MIN_MATCH   = 2;
    localparam int NUM_LENGTHS = MAX_MATCH - MIN_MATCH + 1;

    // Width of the emitted codeword counter
    localparam int COUNT_WIDTH = 12;

    // One input byte with its end-of-stream marker
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } byte_beat_t;

    // Length code is the match length minus two
    typedef enum logic [1:0] {
        LEN2 = 2'd0,
        LEN3 = 2'd1,
        LEN4 = 2'd2,
        LEN5 = 2'd3
    } len_code_e;

    // Literal: flag 0, byte, code 0; match: flag 1, offset, code
    typedef struct packed {
        logic       is_match;
        logic [7:0] field;
        len_code_e  len_code;
    } codeword_t;

    // Slot 0 is the next byte to encode
    typedef struct packed {
        logic [MAX_MATCH-1:0][7:0] bytes;
        logic [2:0]                count;
    } lookahead_t;

    // Bit i set when the match ends i bytes back from the newest history byte
    typedef struct packed {
        logic [WINDOW_SIZE-1:0] len5;
        logic [WINDOW_SIZE-1:0] len4;
        logic [WINDOW_SIZE-1:0] len3;
        logic [WINDOW_SIZE-1:0] len2;
    } match_flags_t;

endpackage

//--- hdl/match_select.sv
`timescale 1ns/1ps

module match_select (
    input  lzss_pkg::match_flags_t  flags,
    input  lzss_pkg::lookahead_t    look,
    output lzss_pkg::codeword_t     cand,
    output logic [2:0]              cand_len
);

    logic [lzss_pkg::NUM_LENGTHS-1:0][lzss_pkg::WINDOW_SIZE-1:0] by_len;
    logic [lzss_pkg::NUM_LENGTHS-1:0]       hit;
    logic [lzss_pkg::NUM_LENGTHS-1:0][7:0]  nearest;

    // Index 0 is length 2
    assign by_len = {flags.len5, flags.len4, flags.len3, flags.len2};

    // Lowest set bit per length is the most recent occurrence
    always_comb begin
        for (int l = 0; l < lzss_pkg::NUM_LENGTHS; l++) begin
            hit[l]     = |by_len[l];
            nearest[l] = '0;
            for (int i = lzss_pkg::WINDOW_SIZE - 1; i >= 0; i--) begin
                if (by_len[l][i]) begin
                    nearest[l] = 8'(i);
                end
            end
        end
    end

    // Literal by default; longer hits override shorter ones
    always_comb begin
        cand     = '{is_match: 1'b0, field: look.bytes[0], len_code: lzss_pkg::LEN2};
        cand_len = 3'd1;
        for (int l = 0; l < lzss_pkg::NUM_LENGTHS; l++) begin
            if (hit[l]) begin
                cand.is_match = 1'b1;
                cand.field    = nearest[l];
                cand.len_code = lzss_pkg::len_code_e'(l);
                cand_len      = 3'(l + lzss_pkg::MIN_MATCH);
            end
        end
    end

endmodule

//--- lzss_encoder.f
hdl/lzss_pkg.sv
hdl/lookahead_buffer.sv
hdl/history_window.sv
hdl/match_select.sv
hdl/encode_control.sv
hdl/lzss_encoder.sv
bench/lzss_checker.sv
bench/tb_lzss.sv
